//--- verilog/simd_alu_pkg.sv
package simd_alu_pkg;

  // Widest element and byte size in bits
  localparam int ELEN_MAX = 64;
  localparam int BYTE_W   = 8;

  // Element width
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Operation code
  typedef enum logic [4:0] {
    VNOP,
    // Logical
    VAND,
    VOR,
    VXOR,
    // Wrapping arithmetic
    VADD,
    VSUB,
    VRSUB,
    // Saturating arithmetic
    VSADDU,
    VSADD,
    VSSUBU,
    VSSUB,
    // Min and max
    VMIN,
    VMINU,
    VMAX,
    VMAXU,
    // Mask compares write bit 0 of each element
    VMSEQ,
    VMSNE,
    VMSLT,
    VMSLTU,
    VMSLE,
    VMSLEU,
    VMSGT,
    VMSGTU
  } alu_op_e;

endpackage : simd_alu_pkg

//--- verilog/simd_add_sub.sv
`timescale 1ns/1ps

module simd_add_sub #(
  parameter int unsigned DataWidth = 64
) (
  input  simd_alu_pkg::alu_op_e                         op_i,
  input  simd_alu_pkg::vew_e                            vew_i,
  input  logic [DataWidth-1:0]                          operand_a_i,
  input  logic [DataWidth-1:0]                          operand_b_i,
  output logic [DataWidth-1:0]                          result_o,
  output logic [DataWidth/simd_alu_pkg::BYTE_W-1:0]     vxsat_o
);

  localparam int unsigned NumBytes = DataWidth / simd_alu_pkg::BYTE_W;
  localparam int unsigned NumEw    = $clog2(simd_alu_pkg::ELEN_MAX / simd_alu_pkg::BYTE_W) + 1;

  // One candidate result per element width
  logic [NumEw-1:0][DataWidth-1:0] res_w;
  logic [NumEw-1:0][NumBytes-1:0]  sat_w;

  ////////////////////////////////////////
  // Lane arithmetic
  ////////////////////////////////////////

  for (genvar w = 0; w < NumEw; w++) begin : gen_width
    localparam int unsigned Ew        = simd_alu_pkg::BYTE_W << w;
    localparam int unsigned LaneBytes = Ew / simd_alu_pkg::BYTE_W;

    if (Ew > DataWidth) begin : gen_off
      // Element wider than the datapath
      assign res_w[w] = '0;
      assign sat_w[w] = '0;
    end else begin : gen_on
      for (genvar l = 0; l < DataWidth / Ew; l++) begin : gen_lane
        logic [Ew-1:0] op_a;
        logic [Ew-1:0] op_b;
        logic [Ew:0]   sum;
        logic [Ew:0]   dif;
        logic [Ew-1:0] rdif;
        logic [Ew-1:0] lane_res;
        logic          lane_sat;

        assign op_a = operand_a_i[l*Ew +: Ew];
        assign op_b = operand_b_i[l*Ew +: Ew];
        assign sum  = {1'b0, op_a} + {1'b0, op_b};
        // Subtract is b - a and reverse subtract is a - b
        assign dif  = {1'b0, op_b} - {1'b0, op_a};
        assign rdif = op_a - op_b;

        always_comb begin
          lane_res = '0;
          lane_sat = 1'b0;
          unique case (op_i)
            simd_alu_pkg::VADD:  lane_res = sum[Ew-1:0];
            simd_alu_pkg::VSUB:  lane_res = dif[Ew-1:0];
            simd_alu_pkg::VRSUB: lane_res = rdif;
            simd_alu_pkg::VSADDU: begin
              lane_sat = sum[Ew];
              lane_res = lane_sat ? {Ew{1'b1}} : sum[Ew-1:0];
            end
            simd_alu_pkg::VSSUBU: begin
              // Borrow clamps to zero
              lane_sat = dif[Ew];
              lane_res = lane_sat ? {Ew{1'b0}} : dif[Ew-1:0];
            end
            simd_alu_pkg::VSADD: begin
              lane_sat = (op_a[Ew-1] == op_b[Ew-1]) && (sum[Ew-1] != op_a[Ew-1]);
              if (lane_sat) begin
                lane_res = op_a[Ew-1] ? {1'b1, {(Ew-1){1'b0}}} : {1'b0, {(Ew-1){1'b1}}};
              end else begin
                lane_res = sum[Ew-1:0];
              end
            end
            simd_alu_pkg::VSSUB: begin
              // Overflow needs differing signs and clamps toward the sign of b
              lane_sat = (op_a[Ew-1] != op_b[Ew-1]) && (dif[Ew-1] != op_b[Ew-1]);
              if (lane_sat) begin
                lane_res = op_b[Ew-1] ? {1'b1, {(Ew-1){1'b0}}} : {1'b0, {(Ew-1){1'b1}}};
              end else begin
                lane_res = dif[Ew-1:0];
              end
            end
            default: ;
          endcase
        end

        assign res_w[w][l*Ew +: Ew]               = lane_res;
        assign sat_w[w][l*LaneBytes +: LaneBytes] = {LaneBytes{lane_sat}};
      end
    end
  end

  assign result_o = res_w[vew_i];
  assign vxsat_o  = sat_w[vew_i];

endmodule : simd_add_sub

//--- verilog/simd_compare.sv
`timescale 1ns/1ps

module simd_compare #(
  parameter int unsigned DataWidth = 64
) (
  input  simd_alu_pkg::alu_op_e op_i,
  input  simd_alu_pkg::vew_e    vew_i,
  input  logic [DataWidth-1:0]  operand_a_i,
  input  logic [DataWidth-1:0]  operand_b_i,
  output logic [DataWidth-1:0]  result_o
);

  localparam int unsigned NumEw = $clog2(simd_alu_pkg::ELEN_MAX / simd_alu_pkg::BYTE_W) + 1;

  logic [NumEw-1:0][DataWidth-1:0] res_w;
  logic                            is_signed;

  assign is_signed = op_i inside {simd_alu_pkg::VMIN, simd_alu_pkg::VMAX, simd_alu_pkg::VMSLT,
                                  simd_alu_pkg::VMSLE, simd_alu_pkg::VMSGT};

  ////////////////////////////////////////
  // Lane compare
  ////////////////////////////////////////

  for (genvar w = 0; w < NumEw; w++) begin : gen_width
    localparam int unsigned Ew = simd_alu_pkg::BYTE_W << w;

    if (Ew > DataWidth) begin : gen_off
      assign res_w[w] = '0;
    end else begin : gen_on
      for (genvar l = 0; l < DataWidth / Ew; l++) begin : gen_lane
        logic [Ew-1:0] op_a;
        logic [Ew-1:0] op_b;
        logic          less;
        logic          equal;
        logic [Ew-1:0] lane_res;

        assign op_a  = operand_a_i[l*Ew +: Ew];
        assign op_b  = operand_b_i[l*Ew +: Ew];
        // Is b below a, with one extra bit holding the sign or a zero
        assign less  = $signed({is_signed & op_b[Ew-1], op_b}) <
                       $signed({is_signed & op_a[Ew-1], op_a});
        assign equal = op_a == op_b;

        always_comb begin
          lane_res = '0;
          unique case (op_i)
            simd_alu_pkg::VMIN,
            simd_alu_pkg::VMINU:  lane_res = less ? op_b : op_a;
            simd_alu_pkg::VMAX,
            simd_alu_pkg::VMAXU:  lane_res = less ? op_a : op_b;
            simd_alu_pkg::VMSEQ:  lane_res[0] = equal;
            simd_alu_pkg::VMSNE:  lane_res[0] = !equal;
            simd_alu_pkg::VMSLT,
            simd_alu_pkg::VMSLTU: lane_res[0] = less;
            simd_alu_pkg::VMSLE,
            simd_alu_pkg::VMSLEU: lane_res[0] = less || equal;
            simd_alu_pkg::VMSGT,
            simd_alu_pkg::VMSGTU: lane_res[0] = !(less || equal);
            default: ;
          endcase
        end

        assign res_w[w][l*Ew +: Ew] = lane_res;
      end
    end
  end

  assign result_o = res_w[vew_i];

endmodule : simd_compare

//--- verilog/simd_result_sel.sv
`timescale 1ns/1ps

module simd_result_sel #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      valid_i,
  input  simd_alu_pkg::alu_op_e                     op_i,
  input  logic [DataWidth-1:0]                      operand_a_i,
  input  logic [DataWidth-1:0]                      operand_b_i,
  input  logic [DataWidth-1:0]                      arith_res_i,
  input  logic [DataWidth/simd_alu_pkg::BYTE_W-1:0] arith_sat_i,
  input  logic [DataWidth-1:0]                      cmp_res_i,
  output logic [DataWidth-1:0]                      result_o,
  output logic [DataWidth/simd_alu_pkg::BYTE_W-1:0] vxsat_o,
  output logic                                      valid_o
);

  logic [DataWidth-1:0] logic_res;
  logic [DataWidth-1:0] comb_res;

  ////////////////////////////////////////
  // Logical ops
  ////////////////////////////////////////

  // Bitwise, so the element width does not matter
  always_comb begin
    logic_res = '0;
    unique case (op_i)
      simd_alu_pkg::VAND: logic_res = operand_a_i & operand_b_i;
      simd_alu_pkg::VOR:  logic_res = operand_a_i | operand_b_i;
      simd_alu_pkg::VXOR: logic_res = operand_a_i ^ operand_b_i;
      default: ;
    endcase
  end

  // Units drive zero for ops they do not own
  assign comb_res = logic_res | arith_res_i | cmp_res_i;

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i || !valid_i) begin
      result_o <= '0;
      vxsat_o  <= '0;
      valid_o  <= 1'b0;
    end else begin
      result_o <= comb_res;
      vxsat_o  <= arith_sat_i;
      valid_o  <= 1'b1;
    end
  end

endmodule : simd_result_sel

//--- verilog/simd_alu.sv
`timescale 1ns/1ps

module simd_alu #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      valid_i,
  input  simd_alu_pkg::alu_op_e                     op_i,
  input  simd_alu_pkg::vew_e                        vew_i,
  input  logic [DataWidth-1:0]                      operand_a_i,
  input  logic [DataWidth-1:0]                      operand_b_i,
  output logic [DataWidth-1:0]                      result_o,
  output logic [DataWidth/simd_alu_pkg::BYTE_W-1:0] vxsat_o,
  output logic                                      valid_o
);

  logic [DataWidth-1:0]                      arith_res;
  logic [DataWidth/simd_alu_pkg::BYTE_W-1:0] arith_sat;
  logic [DataWidth-1:0]                      cmp_res;

  simd_add_sub #(
    .DataWidth (DataWidth)
  ) u_simd_add_sub (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (arith_res),
    .vxsat_o     (arith_sat)
  );

  simd_compare #(
    .DataWidth (DataWidth)
  ) u_simd_compare (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (cmp_res)
  );

  // Logical ops, merge and the single register stage
  simd_result_sel #(
    .DataWidth (DataWidth)
  ) u_simd_result_sel (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .arith_res_i (arith_res),
    .arith_sat_i (arith_sat),
    .cmp_res_i   (cmp_res),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o),
    .valid_o     (valid_o)
  );

endmodule : simd_alu

//--- test/tb_simd_alu_ref.svh
`ifndef TB_SIMD_ALU_REF_SVH
`define TB_SIMD_ALU_REF_SVH

// Next state of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Expected result and per-byte saturation for one 64-bit operation
function automatic void alu_expect(
  input  simd_alu_pkg::alu_op_e op,
  input  simd_alu_pkg::vew_e    vew,
  input  logic [63:0]           a,
  input  logic [63:0]           b,
  output logic [63:0]           res,
  output logic [7:0]            sat
);
  int unsigned        ew;
  logic [63:0]        mask;
  logic [63:0]        ea;
  logic [63:0]        eb;
  logic [63:0]        lane;
  logic signed [65:0] ua;
  logic signed [65:0] ub;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] full;
  logic signed [65:0] smax;
  logic signed [65:0] smin;
  logic               flag;
  ew   = 8 << vew;
  mask = (ew == 64) ? {64{1'b1}} : ((64'd1 << ew) - 64'd1);
  smax = {2'b00, mask >> 1};
  smin = -smax - 1;
  res  = '0;
  sat  = '0;
  for (int unsigned i = 0; i < 64 / ew; i++) begin
    ea   = (a >> (i * ew)) & mask;
    eb   = (b >> (i * ew)) & mask;
    ua   = {2'b00, ea};
    ub   = {2'b00, eb};
    // Exact signed values of the elements
    sa   = ea[ew-1] ? {2'b11, ea | ~mask} : {2'b00, ea};
    sb   = eb[ew-1] ? {2'b11, eb | ~mask} : {2'b00, eb};
    lane = '0;
    flag = 1'b0;
    case (op)
      simd_alu_pkg::VAND:  lane = ea & eb;
      simd_alu_pkg::VOR:   lane = ea | eb;
      simd_alu_pkg::VXOR:  lane = ea ^ eb;
      simd_alu_pkg::VADD:  lane = ea + eb;
      simd_alu_pkg::VSUB:  lane = eb - ea;
      simd_alu_pkg::VRSUB: lane = ea - eb;
      simd_alu_pkg::VSADDU: begin
        full = ua + ub;
        flag = full > {2'b00, mask};
        lane = flag ? mask : full[63:0];
      end
      simd_alu_pkg::VSSUBU: begin
        full = ub - ua;
        flag = full < 0;
        lane = flag ? 64'd0 : full[63:0];
      end
      simd_alu_pkg::VSADD,
      simd_alu_pkg::VSSUB: begin
        full = (op == simd_alu_pkg::VSADD) ? sa + sb : sb - sa;
        flag = (full > smax) || (full < smin);
        if (full > smax) begin
          full = smax;
        end else if (full < smin) begin
          full = smin;
        end
        lane = full[63:0];
      end
      simd_alu_pkg::VMIN:   lane = (sb < sa) ? eb : ea;
      simd_alu_pkg::VMINU:  lane = (ub < ua) ? eb : ea;
      simd_alu_pkg::VMAX:   lane = (sb > sa) ? eb : ea;
      simd_alu_pkg::VMAXU:  lane = (ub > ua) ? eb : ea;
      simd_alu_pkg::VMSEQ:  lane = (eb == ea);
      simd_alu_pkg::VMSNE:  lane = (eb != ea);
      simd_alu_pkg::VMSLT:  lane = (sb < sa);
      simd_alu_pkg::VMSLTU: lane = (ub < ua);
      simd_alu_pkg::VMSLE:  lane = (sb <= sa);
      simd_alu_pkg::VMSLEU: lane = (ub <= ua);
      simd_alu_pkg::VMSGT:  lane = (sb > sa);
      simd_alu_pkg::VMSGTU: lane = (ub > ua);
      default: lane = '0;
    endcase
    res = res | ((lane & mask) << (i * ew));
    for (int unsigned k = 0; k < ew / 8; k++) begin
      sat[i * ew / 8 + k] = flag;
    end
  end
endfunction

`endif

//--- test/tb_simd_alu.sv
`timescale 1ns/1ps

module tb_simd_alu;

  localparam int NumOps     = 22;
  localparam int NumVectors = 40;
  // Reset plus one idle cycle after each op and width group
  localparam int TestCycles = 4 + NumOps * 4 * (NumVectors + 1);
  localparam int MaxCycles  = 4000;

  logic                  clk_i;
  logic                  reset_i;
  logic                  valid_i;
  simd_alu_pkg::alu_op_e op_i;
  simd_alu_pkg::vew_e    vew_i;
  logic [63:0]           operand_a_i;
  logic [63:0]           operand_b_i;
  logic [63:0]           result_o;
  logic [7:0]            vxsat_o;
  logic                  valid_o;

  logic [134:0] issue_q[$];
  int unsigned  issue_cyc_q[$];
  int unsigned  cycle     = 0;
  int unsigned  n_checked = 0;
  logic [31:0]  rand_state = 32'd47946;

  `include "tb_simd_alu_ref.svh"

  simd_alu #(
    .DataWidth (64)
  ) u_simd_alu (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o),
    .valid_o     (valid_o)
  );

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic random_word(output logic [63:0] word);
    logic [31:0] hi;
    rand_state = lcg_next(rand_state);
    hi         = rand_state;
    rand_state = lcg_next(rand_state);
    word       = {hi, rand_state};
  endtask

  // Top bit of every element of the given width
  function automatic logic [63:0] lane_msbs(input int unsigned ew);
    logic [63:0] m;
    m = '0;
    for (int unsigned i = ew - 1; i < 64; i += ew) begin
      m[i] = 1'b1;
    end
    return m;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MaxCycles) begin
      $display("Timeout after %0d cycles, the test should need about %0d", MaxCycles,
               TestCycles);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] smin;
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    op_i        = simd_alu_pkg::VNOP;
    vew_i       = simd_alu_pkg::EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (4) @(posedge clk_i);
    #10 reset_i = 1'b0;
    for (int o = 1; o <= NumOps; o++) begin
      for (int w = 0; w < 4; w++) begin
        smin = lane_msbs(8 << w);
        for (int j = 0; j < NumVectors; j++) begin
          @(posedge clk_i);
          #10;
          random_word(ra);
          random_word(rb);
          // Extreme and equal operands first and random ones after
          case (j)
            0:       operand_a_i = ra;
            1, 3:    operand_a_i = ~smin;
            2, 4, 8: operand_a_i = smin;
            5, 7:    operand_a_i = '1;
            6, 9:    operand_a_i = '0;
            10:      operand_a_i = ra ^ smin;
            default: operand_a_i = ra;
          endcase
          case (j)
            0, 10:   operand_b_i = ra;
            1, 4:    operand_b_i = ~smin;
            2, 3, 9: operand_b_i = smin;
            5, 6:    operand_b_i = '1;
            7, 8:    operand_b_i = '0;
            default: operand_b_i = rb;
          endcase
          op_i    = simd_alu_pkg::alu_op_e'(o);
          vew_i   = simd_alu_pkg::vew_e'(w);
          valid_i = 1'b1;
          issue_q.push_back({op_i, vew_i, operand_a_i, operand_b_i});
          issue_cyc_q.push_back(cycle);
        end
        // Idle cycle with live operands on the bus
        @(posedge clk_i);
        #10;
        random_word(operand_a_i);
        valid_i = 1'b0;
      end
    end
    while (issue_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    if (n_checked != NumOps * 4 * NumVectors) begin
      $display("Only %0d of %0d results were checked", n_checked, NumOps * 4 * NumVectors);
      abort_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  initial begin
    logic [134:0] entry;
    int unsigned  issued;
    logic [63:0]  exp_res;
    logic [7:0]   exp_sat;
    // Output register is unknown until the first edge in reset
    @(posedge clk_i);
    forever begin
      @(negedge clk_i);
      if (valid_o === 1'b1) begin
        if (issue_q.size() == 0) begin
          $display("At %0t valid_o was high with no operation outstanding", $time);
          abort_run();
        end
        entry  = issue_q.pop_front();
        issued = issue_cyc_q.pop_front();
        if (issued + 1 != cycle) begin
          $display("At %0t a result issued in cycle %0d arrived in cycle %0d", $time,
                   issued, cycle);
          abort_run();
        end
        alu_expect(simd_alu_pkg::alu_op_e'(entry[134:130]), simd_alu_pkg::vew_e'(entry[129:128]),
                   entry[127:64], entry[63:0], exp_res, exp_sat);
        check_equal("result_o", exp_res, result_o);
        check_equal("vxsat_o", {56'd0, exp_sat}, {56'd0, vxsat_o});
        n_checked++;
      end else begin
        check_equal("valid_o", 64'd0, {63'd0, valid_o});
        check_equal("result_o", 64'd0, result_o);
        check_equal("vxsat_o", 64'd0, {56'd0, vxsat_o});
        if (issue_cyc_q.size() != 0 && issue_cyc_q[0] + 1 <= cycle) begin
          $display("At %0t valid_o stayed low for an operation issued in cycle %0d", $time,
                   issue_cyc_q[0]);
          abort_run();
        end
      end
    end
  end

endmodule : tb_simd_alu

//--- simd_alu.f
+incdir+test
verilog/simd_alu_pkg.sv
verilog/simd_add_sub.sv
verilog/simd_compare.sv
verilog/simd_result_sel.sv
verilog/simd_alu.sv
test/tb_simd_alu.sv

//--- Bender.yml
package:
  name: simd_alu

sources:
  - verilog/simd_alu_pkg.sv
  - verilog/simd_add_sub.sv
  - verilog/simd_compare.sv
  - verilog/simd_result_sel.sv
  - verilog/simd_alu.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_simd_alu.sv
